// ==== Bender.yml ====
package:
  name: ifu

sources:
  - common/ifu_pkg.sv
  - hw/ifu/ifu_ifetch.sv
  - hw/ifu/ifu_axi_master.sv
  - hw/ifu/sbpu.sv
  - hw/ifu/ifu_pipe.sv
  - hw/ifu/ifu.sv
  - target: test
    files:
      - testbench/tb_axi_mem.sv
      - testbench/tb_ifu.sv

// ==== all.f ====
common/ifu_pkg.sv
hw/ifu/ifu_ifetch.sv
hw/ifu/ifu_axi_master.sv
hw/ifu/sbpu.sv
hw/ifu/ifu_pipe.sv
hw/ifu/ifu.sv
testbench/tb_axi_mem.sv
testbench/tb_ifu.sv

// ==== common/ifu_pkg.sv ====
/*
 * Shared widths, AXI encodings and packed payload types for the fetch unit.
 * Modules import this package inside their body and use scoped names in ports.
 */

package ifu_pkg;

    localparam int ADDR_W = 32;             // instruction address width
    localparam int DATA_W = 64;             // one aligned beat, two slots
    localparam int ID_W   = 4;              // axi transaction id

    // axi encodings used by the fetch master
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;
    localparam logic [2:0] AXI_SIZE_8B    = 3'd3;  // 8 bytes per beat
    localparam logic [1:0] AXI_RESP_OKAY  = 2'b00;

    // rv32i opcodes the predictor looks at
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    typedef logic [31:0] inst_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;            // jump or predicted target
    } redirect_t;

    typedef struct packed {
        logic stall;                        // hold bundle, block bus
        logic flush;                        // drop bundle
    } cu_ctrl_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;
        logic [2:0]        size;
        logic [1:0]        burst;
    } axi_ar_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
        logic              last;
    } axi_r_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [ADDR_W-1:0] addr;            // 8-byte aligned base
        logic              offset_hi;       // fetch pc bit 2
    } fetch_beat_t;

    typedef struct packed {
        logic              valid;
        inst_t             inst;
        logic [ADDR_W-1:0] addr;
        logic              pred_taken;
    } fetch_slot_t;

    typedef struct packed {
        fetch_slot_t slot0;                 // lower word, base + 0
        fetch_slot_t slot1;                 // upper word, base + 4
    } fetch_bundle_t;

endpackage

// ==== hw/ifu/ifu.sv ====
/*
 * Dual-issue instruction fetch unit top. PC generator and AXI read master
 * on the input side, static predictor in the middle, bundle register out.
 * RESET_PC and AXI_ID are passed down from here.
 */

`timescale 1ns/1ps

module ifu #(
    parameter logic [ifu_pkg::ADDR_W-1:0] RESET_PC = 32'h0000_1000,
    parameter logic [ifu_pkg::ID_W-1:0]   AXI_ID   = '0
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  ifu_pkg::redirect_t     jump_i,             // control unit jump
    input  ifu_pkg::cu_ctrl_t      ctrl_i,             // stall / flush
    output ifu_pkg::fetch_bundle_t bundle_o,
    output logic                   inst_valid_o,
    output logic                   read_resp_error_o,
    output logic                   pc_misaligned_o,
    output ifu_pkg::axi_ar_t       ar_o,
    output logic                   ar_valid_o,
    input  logic                   ar_ready_i,
    input  ifu_pkg::axi_r_t        r_i,
    input  logic                   r_valid_i,
    output logic                   r_ready_o
);

    import ifu_pkg::*;

    logic [ADDR_W-1:0] pc;
    logic              fetch_en;
    fetch_beat_t       beat;
    logic              beat_fire;                      // good beat
    logic              beat_done;                      // live beat, ok or error
    redirect_t         pred;
    fetch_bundle_t     slots;

    ifu_ifetch #(
        .RESET_PC        (RESET_PC)
    ) i_ifu_ifetch (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .jump_i          (jump_i),
        .pred_i          (pred),
        .beat_done_i     (beat_done),
        .pc_o            (pc),
        .fetch_en_o      (fetch_en),
        .pc_misaligned_o (pc_misaligned_o)
    );

    ifu_axi_master #(
        .AXI_ID            (AXI_ID)
    ) i_ifu_axi_master (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .pc_i              (pc),
        .fetch_en_i        (fetch_en),
        .stall_i           (ctrl_i.stall),             // back-pressure to bus
        .jump_valid_i      (jump_i.valid),             // marks pending read stale
        .ar_o              (ar_o),
        .ar_valid_o        (ar_valid_o),
        .ar_ready_i        (ar_ready_i),
        .r_i               (r_i),
        .r_valid_i         (r_valid_i),
        .r_ready_o         (r_ready_o),
        .beat_o            (beat),
        .beat_fire_o       (beat_fire),
        .beat_done_o       (beat_done),
        .read_resp_error_o (read_resp_error_o)
    );

    sbpu i_sbpu (
        .beat_i      (beat),
        .beat_fire_i (beat_fire),
        .pred_o      (pred),
        .slots_o     (slots)
    );

    ifu_pipe i_ifu_pipe (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .slots_i      (slots),
        .beat_fire_i  (beat_fire),
        .ctrl_i       (ctrl_i),
        .bundle_o     (bundle_o),
        .inst_valid_o (inst_valid_o)
    );

endmodule

// ==== hw/ifu/ifu_axi_master.sv ====
/*
 * Single-outstanding AXI4 read master for instruction fetch. Issues one
 * aligned 64-bit beat per request, drops beats made stale by a jump and
 * flags non-OKAY responses. Beat outputs are valid in the accept cycle.
 */

`timescale 1ns/1ps

module ifu_axi_master #(
    parameter logic [ifu_pkg::ID_W-1:0] AXI_ID = '0
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic [ifu_pkg::ADDR_W-1:0]  pc_i,
    input  logic                        fetch_en_i,
    input  logic                        stall_i,
    input  logic                        jump_valid_i,
    output ifu_pkg::axi_ar_t            ar_o,
    output logic                        ar_valid_o,
    input  logic                        ar_ready_i,
    input  ifu_pkg::axi_r_t             r_i,
    input  logic                        r_valid_i,
    output logic                        r_ready_o,
    output ifu_pkg::fetch_beat_t        beat_o,
    output logic                        beat_fire_o,      // good beat for sbpu/pipe
    output logic                        beat_done_o,      // any live beat, pc steps
    output logic                        read_resp_error_o
);

    import ifu_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_AR,
        S_R
    } state_e;

    state_e            state_q;
    logic [ADDR_W-1:0] addr_q;                            // aligned request address
    logic              offset_hi_q;                       // pc bit 2 at request
    logic              stale_q;                           // jump hit pending read
    logic              start;
    logic              accept;
    logic              stale_now;

    // a jump in the issue cycle would fetch the old pc, so wait a cycle
    assign start     = (state_q == S_IDLE) & fetch_en_i & ~stall_i & ~jump_valid_i;
    assign r_ready_o = (state_q == S_R) & ~stall_i;
    assign accept    = r_valid_i & r_ready_o;
    assign stale_now = stale_q | jump_valid_i;            // jump on accept edge too

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= S_IDLE;
            stale_q <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (start) begin
                        state_q <= S_AR;
                    end
                end
                S_AR: begin
                    if (jump_valid_i) stale_q <= 1'b1;
                    if (ar_ready_i) begin
                        state_q <= S_R;
                    end
                end
                S_R: begin
                    if (jump_valid_i) stale_q <= 1'b1;
                    if (accept) begin
                        state_q <= S_IDLE;
                        stale_q <= 1'b0;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // request payload, captured once per fetch
    always_ff @(posedge clk_i) begin
        if (start) begin
            addr_q      <= {pc_i[ADDR_W-1:3], 3'b000};
            offset_hi_q <= pc_i[2];
        end
    end

    always_comb begin
        ar_o.id    = AXI_ID;
        ar_o.addr  = addr_q;
        ar_o.len   = 8'd0;                                // single beat
        ar_o.size  = AXI_SIZE_8B;
        ar_o.burst = AXI_BURST_INCR;
    end
    assign ar_valid_o = (state_q == S_AR);

    assign beat_o.data      = r_i.data;
    assign beat_o.addr      = addr_q;
    assign beat_o.offset_hi = offset_hi_q;

    assign beat_done_o       = accept & ~stale_now;
    assign beat_fire_o       = beat_done_o & (r_i.resp == AXI_RESP_OKAY);
    assign read_resp_error_o = beat_done_o & (r_i.resp != AXI_RESP_OKAY);

    a_ar_stable : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o)
    );

    // len 0 request, so the slave must close it in one beat
    a_r_last : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        r_valid_i && r_ready_o |-> r_i.last
    );

endmodule

// ==== hw/ifu/ifu_ifetch.sv ====
/*
 * Fetch PC register. Picks the next PC from an external jump, the predicted
 * target or the next sequential beat, and halts fetch on a misaligned target
 * until an aligned jump arrives.
 */

`timescale 1ns/1ps

module ifu_ifetch #(
    parameter logic [ifu_pkg::ADDR_W-1:0] RESET_PC = 32'h0000_1000
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  ifu_pkg::redirect_t          jump_i,          // control unit jump
    input  ifu_pkg::redirect_t          pred_i,          // from sbpu
    input  logic                        beat_done_i,     // beat consumed, advance
    output logic [ifu_pkg::ADDR_W-1:0]  pc_o,
    output logic                        fetch_en_o,
    output logic                        pc_misaligned_o
);

    import ifu_pkg::*;

    logic [ADDR_W-1:0] pc_q;
    logic              misaligned_q;                     // sticky until aligned jump
    logic [ADDR_W-1:0] seq_pc;                           // next beat base
    logic              redir_valid;
    logic [ADDR_W-1:0] redir_addr;

    assign seq_pc = {pc_q[ADDR_W-1:3], 3'b000} + ADDR_W'(8);

    // jump always wins, prediction only counts with a consumed beat
    always_comb begin
        redir_valid = jump_i.valid | (beat_done_i & pred_i.valid & ~misaligned_q);
        redir_addr  = jump_i.valid ? jump_i.addr : pred_i.addr;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q         <= RESET_PC;
            misaligned_q <= 1'b0;
        end else if (redir_valid) begin
            if (redir_addr[1:0] != 2'b00) begin
                misaligned_q <= 1'b1;                    // halt, pc keeps old value
            end else begin
                pc_q         <= redir_addr;
                misaligned_q <= 1'b0;
            end
        end else if (beat_done_i && !misaligned_q) begin
            pc_q <= seq_pc;                              // error beats also step on
        end
    end

    assign pc_o            = pc_q;
    assign fetch_en_o      = ~misaligned_q;
    assign pc_misaligned_o = misaligned_q;

    // only a jump may move the pc once fetch is halted
    a_no_advance_misaligned : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        misaligned_q && !jump_i.valid |=> $stable(pc_q)
    );

endmodule

// ==== hw/ifu/ifu_pipe.sv ====
/*
 * Fetch bundle output register toward decode. Loads a new bundle on every
 * good beat, holds it under stall and drops the valid bit on flush.
 */

`timescale 1ns/1ps

module ifu_pipe (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  ifu_pkg::fetch_bundle_t slots_i,
    input  logic                   beat_fire_i,
    input  ifu_pkg::cu_ctrl_t      ctrl_i,
    output ifu_pkg::fetch_bundle_t bundle_o,
    output logic                   inst_valid_o
);

    import ifu_pkg::*;

    fetch_bundle_t bundle_q;
    logic          valid_q;
    logic          load;

    assign load = ~ctrl_i.stall;                 // decode can take a bundle

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (ctrl_i.flush) begin
            valid_q <= 1'b0;                     // flush beats stall
        end else if (load) begin
            valid_q <= beat_fire_i;              // bubble when no beat
        end
    end

    // bundle payload, taken with each good beat
    always_ff @(posedge clk_i) begin
        if (load && beat_fire_i) begin
            bundle_q <= slots_i;
        end
    end

    assign bundle_o     = bundle_q;
    assign inst_valid_o = valid_q;

    // decode relies on an unchanged bundle across a stall
    a_hold_on_stall : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        valid_q && ctrl_i.stall && !ctrl_i.flush |=> valid_q && $stable(bundle_o)
    );

endmodule

// ==== hw/ifu/sbpu.sv ====
/*
 * Static branch predictor for a two-slot fetch beat. JAL and backward
 * conditional branches are predicted taken. Purely combinational; builds
 * the slot bundle and the first taken target for the PC generator.
 */

`timescale 1ns/1ps

module sbpu (
    input  ifu_pkg::fetch_beat_t   beat_i,
    input  logic                   beat_fire_i,
    output ifu_pkg::redirect_t     pred_o,
    output ifu_pkg::fetch_bundle_t slots_o
);

    import ifu_pkg::*;

    inst_t             inst0;
    inst_t             inst1;
    logic [ADDR_W-1:0] addr0;
    logic [ADDR_W-1:0] addr1;
    redirect_t         dec0;                     // valid = taken
    redirect_t         dec1;
    logic              valid0;
    logic              valid1;
    logic              taken0;
    logic              taken1;

    // per-slot decode, target is pc relative
    function automatic redirect_t predict(input inst_t inst, input logic [ADDR_W-1:0] pc);
        logic [ADDR_W-1:0] imm_j;
        logic [ADDR_W-1:0] imm_b;
        redirect_t         res;
        imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        res.valid = 1'b0;
        res.addr  = pc + imm_b;
        if (inst[6:0] == OPC_JAL) begin
            res.valid = 1'b1;
            res.addr  = pc + imm_j;
        end else if (inst[6:0] == OPC_BRANCH) begin
            res.valid = inst[31];                // negative offset, loop back
        end
        return res;
    endfunction

    assign inst0 = beat_i.data[31:0];
    assign inst1 = beat_i.data[63:32];
    assign addr0 = beat_i.addr;
    assign addr1 = beat_i.addr + ADDR_W'(4);

    assign dec0 = predict(inst0, addr0);
    assign dec1 = predict(inst1, addr1);

    assign valid0 = ~beat_i.offset_hi;           // jumped into upper word
    assign taken0 = valid0 & dec0.valid;
    assign valid1 = ~taken0;                     // shadow of a taken slot0
    assign taken1 = valid1 & dec1.valid;

    always_comb begin
        slots_o.slot0.valid      = valid0;
        slots_o.slot0.inst       = inst0;
        slots_o.slot0.addr       = addr0;
        slots_o.slot0.pred_taken = taken0;
        slots_o.slot1.valid      = valid1;
        slots_o.slot1.inst       = inst1;
        slots_o.slot1.addr       = addr1;
        slots_o.slot1.pred_taken = taken1;
    end

    // first taken slot wins
    assign pred_o.valid = beat_fire_i & (taken0 | taken1);
    assign pred_o.addr  = taken0 ? dec0.addr : dec1.addr;

endmodule

// ==== testbench/tb_axi_mem.sv ====
/*
 * AXI4 read slave memory model for the fetch unit testbench. One read at a
 * time, response latency set by the running test, one address can answer SLVERR.
 */

`timescale 1ns/1ps

module tb_axi_mem (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  ifu_pkg::axi_ar_t ar_i,
    input  logic             ar_valid_i,
    output logic             ar_ready_o,
    output ifu_pkg::axi_r_t  r_o,
    output logic             r_valid_o,
    input  logic             r_ready_i
);

    import ifu_pkg::*;

    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic [31:0]       mem [0:1023];            // word array, preloaded by tests
    int unsigned       latency;                 // idle cycles between ar and r
    logic              err_en;
    logic [ADDR_W-1:0] err_addr;                // beat at this address fails
    logic              busy;
    axi_ar_t           req_q;
    int unsigned       cnt;
    logic [9:0]        idx;
    logic [1:0]        resp;

    assign ar_ready_o = ~busy;                  // single outstanding read
    assign idx        = req_q.addr[11:2];       // even word of the beat
    assign resp       = (err_en && req_q.addr == err_addr) ? RESP_SLVERR : AXI_RESP_OKAY;
    assign r_o        = {req_q.id, mem[idx + 10'd1], mem[idx], resp, 1'b1};

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy      <= 1'b0;
            r_valid_o <= 1'b0;
            cnt       <= 0;
        end else if (!busy) begin
            if (ar_valid_i) begin
                busy  <= 1'b1;
                req_q <= ar_i;
                cnt   <= latency;               // sampled per request
            end
        end else if (!r_valid_o) begin
            if (cnt == 0) r_valid_o <= 1'b1;
            else cnt <= cnt - 1;
        end else if (r_ready_i) begin
            r_valid_o <= 1'b0;                  // beat taken
            busy      <= 1'b0;
        end
    end

endmodule

// ==== testbench/tb_ifu.sv ====
/*
 * Directed testbench for the fetch unit against the AXI memory model.
 * Expected bundles are rebuilt from the memory image, the static prediction
 * rules and a table of branch targets kept while the program is written.
 */

`timescale 1ns/1ps

module tb_ifu;

    import ifu_pkg::*;

    localparam logic [31:0] RESET_PC = 32'h0000_0100;
    localparam logic [3:0]  AXI_ID   = 4'h3;

    logic          clk;
    logic          rst_n;
    redirect_t     jump;
    cu_ctrl_t      ctrl;
    fetch_bundle_t bundle;
    logic          inst_valid;
    logic          rd_err;
    logic          misaligned;
    axi_ar_t       ar;
    logic          ar_valid;
    logic          ar_ready;
    axi_r_t        r;
    logic          r_valid;
    logic          r_ready;
    logic [31:0]   tgt [0:1023];                // branch target per word
    int            test_errs;
    int            n_pass;
    int            n_fail;
    int            n_err;

    always #10 clk = ~clk;                      // 20 ns period

    ifu #(
        .RESET_PC (RESET_PC),
        .AXI_ID   (AXI_ID)
    ) i_ifu (
        .clk_i (clk), .rst_n_i (rst_n), .jump_i (jump), .ctrl_i (ctrl),
        .bundle_o (bundle), .inst_valid_o (inst_valid),
        .read_resp_error_o (rd_err), .pc_misaligned_o (misaligned),
        .ar_o (ar), .ar_valid_o (ar_valid), .ar_ready_i (ar_ready),
        .r_i (r), .r_valid_i (r_valid), .r_ready_o (r_ready)
    );

    tb_axi_mem i_mem (
        .clk_i (clk), .rst_n_i (rst_n), .ar_i (ar), .ar_valid_i (ar_valid),
        .ar_ready_o (ar_ready), .r_o (r), .r_valid_o (r_valid), .r_ready_i (r_ready)
    );

    // every request is one aligned 8-byte INCR beat under the fixed id
    always @(negedge clk) begin
        if (rst_n && ar_valid && ar_ready) begin
            if (ar.id !== AXI_ID) begin
                $display("MISMATCH ar_o.id: got %h expected %h", ar.id, AXI_ID);
                test_errs++;
            end
            if (ar.len !== 8'h00) begin
                $display("MISMATCH ar_o.len: got %h expected 00", ar.len);
                test_errs++;
            end
            if (ar.size !== 3'h3) begin
                $display("MISMATCH ar_o.size: got %h expected 3", ar.size);
                test_errs++;
            end
            if (ar.burst !== 2'b01) begin
                $display("MISMATCH ar_o.burst: got %h expected 1", ar.burst);
                test_errs++;
            end
            if (ar.addr[2:0] !== 3'b000) begin
                $display("MISMATCH ar_o.addr[2:0]: got %h expected 0", ar.addr[2:0]);
                test_errs++;
            end
        end
    end

    // op-imm filler, never a branch
    function automatic inst_t fill_word(input logic [31:0] addr);
        return {addr[26:2], 7'b0010011};
    endfunction

    function automatic inst_t enc_jal(input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd0, OPC_JAL};
    endfunction

    function automatic inst_t enc_br(input logic [12:0] off);
        return {off[12], off[10:5], 5'd1, 5'd2, 3'b000, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic is_taken(input inst_t inst);
        return inst[6:0] == OPC_JAL || (inst[6:0] == OPC_BRANCH && inst[31]);
    endfunction

    function automatic fetch_bundle_t model_bundle(input logic [31:0] pc);
        fetch_bundle_t b;
        logic [9:0]    idx;
        idx                = pc[11:2] & 10'h3fe;
        b.slot0.inst       = i_mem.mem[idx];
        b.slot0.addr       = {pc[31:3], 3'b000};
        b.slot0.valid      = ~pc[2];            // entered at upper word
        b.slot0.pred_taken = b.slot0.valid & is_taken(b.slot0.inst);
        b.slot1.inst       = i_mem.mem[idx | 10'h1];
        b.slot1.addr       = {pc[31:3], 3'b100};
        b.slot1.valid      = ~b.slot0.pred_taken;
        b.slot1.pred_taken = b.slot1.valid & is_taken(b.slot1.inst);
        return b;
    endfunction

    function automatic logic [31:0] model_next(input logic [31:0] pc);
        fetch_bundle_t b;
        b = model_bundle(pc);
        if (b.slot0.pred_taken) return tgt[b.slot0.addr[11:2]];
        if (b.slot1.pred_taken) return tgt[b.slot1.addr[11:2]];
        return {pc[31:3], 3'b000} + 32'd8;
    endfunction

    task automatic put_branch(input logic [31:0] addr, input logic [31:0] dest, input bit jal);
        logic [31:0] off;
        off                   = dest - addr;
        i_mem.mem[addr[11:2]] = jal ? enc_jal(off[20:0]) : enc_br(off[12:0]);
        tgt[addr[11:2]]       = dest;
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_jump(input logic [31:0] dest);
        step();
        jump.valid = 1'b1;
        jump.addr  = dest;
        step();
        jump.valid = 1'b0;
    endtask

    task automatic wait_bundle(output bit got, input int limit);
        got = 1'b0;
        for (int c = 0; c < limit && !got; c++) begin
            @(negedge clk);
            got = inst_valid;
        end
    endtask

    // check count bundles along the predicted path from start
    task automatic follow(input logic [31:0] start, input int count, input bit rnd);
        logic [31:0]   pc;
        fetch_bundle_t exp;
        bit            got;
        pc = start;
        for (int n = 0; n < count; n++) begin
            wait_bundle(got, 60);
            if (!got) begin
                $display("no bundle for pc %h within 60 cycles", pc);
                test_errs++;
                return;
            end
            exp = model_bundle(pc);
            if (bundle.slot0 !== exp.slot0) begin
                $display("MISMATCH bundle_o.slot0: got %h expected %h", bundle.slot0, exp.slot0);
                test_errs++;
            end
            if (bundle.slot1 !== exp.slot1) begin
                $display("MISMATCH bundle_o.slot1: got %h expected %h", bundle.slot1, exp.slot1);
                test_errs++;
            end
            pc = model_next(pc);
            if (rnd) i_mem.latency = $urandom % 6;
        end
    endtask

    task automatic report_test(input string name);
        if (test_errs == 0) begin
            $display("%s: PASS", name);
            n_pass++;
        end else begin
            $display("%s: FAIL, %0d errors", name, test_errs);
            n_fail++;
        end
        n_err += test_errs;
    endtask

    task automatic test_sequential();
        test_errs = 0;
        follow(RESET_PC, 8, 1'b1);
        i_mem.latency = 1;
        report_test("sequential fetch");
    endtask

    task automatic test_predict();
        test_errs = 0;
        drive_jump(32'h200);
        follow(32'h200, 5, 1'b0);               // fwd, jal, one trip round the loop
        report_test("static prediction");
    endtask

    task automatic test_jump();
        bit pending;
        test_errs = 0;
        drive_jump(32'h304);
        follow(32'h304, 2, 1'b0);
        i_mem.latency = 8;
        pending = 1'b0;
        for (int c = 0; c < 40 && !pending; c++) begin
            @(negedge clk);
            pending = r_ready & ~r_valid;       // read out, no data yet
        end
        if (!pending) begin
            $display("no read pending within 40 cycles");
            test_errs++;
        end
        drive_jump(32'h280);
        i_mem.latency = 1;
        follow(32'h280, 2, 1'b0);
        report_test("external jump");
    endtask

    task automatic test_misaligned();
        bit got;
        test_errs = 0;
        drive_jump(32'h302);
        @(negedge clk);
        if (misaligned !== 1'b1) begin
            $display("MISMATCH pc_misaligned_o: got %h expected 1", misaligned);
            test_errs++;
        end
        wait_bundle(got, 30);
        if (got) begin
            $display("bundle delivered while fetch was halted");
            test_errs++;
        end
        drive_jump(32'h2c0);
        @(negedge clk);
        if (misaligned !== 1'b0) begin
            $display("MISMATCH pc_misaligned_o: got %h expected 0", misaligned);
            test_errs++;
        end
        follow(32'h2c0, 2, 1'b0);
        report_test("misaligned jump");
    endtask

    task automatic test_stall_flush();
        fetch_bundle_t snap;
        logic [31:0]   pc;
        bit            pending;
        bit            seen;
        test_errs = 0;
        i_mem.latency = 2;
        pending = 1'b0;
        for (int c = 0; c < 40 && !pending; c++) begin
            @(negedge clk);
            pending = r_ready & ~r_valid;       // read out, no data yet
        end
        if (!pending) begin
            $display("no read pending within 40 cycles");
            test_errs++;
        end
        step();
        ctrl.stall = 1'b1;                      // data shows up while stalled
        repeat (5) begin
            @(negedge clk);
            if (r_ready !== 1'b0) begin
                $display("MISMATCH r_ready_o: got %h expected 0", r_ready);
                test_errs++;
            end
        end
        step();
        ctrl.stall = 1'b0;
        seen = 1'b0;
        for (int c = 0; c < 40 && !seen; c++) begin
            @(negedge clk);
            seen = r_valid & r_ready;           // beat taken at next edge
        end
        if (!seen) begin
            $display("no beat offered within 40 cycles");
            test_errs++;
        end
        step();
        ctrl.stall = 1'b1;
        @(negedge clk);
        snap = bundle;
        repeat (5) begin
            if (inst_valid !== 1'b1) begin
                $display("MISMATCH inst_valid_o: got %h expected 1", inst_valid);
                test_errs++;
            end
            if (bundle !== snap) begin
                $display("MISMATCH bundle_o: got %h expected %h", bundle, snap);
                test_errs++;
            end
            if (r_ready !== 1'b0 || ar_valid !== 1'b0) begin
                $display("bus request made during stall");
                test_errs++;
            end
            @(negedge clk);
        end
        step();
        ctrl.flush = 1'b1;
        @(posedge clk);
        @(negedge clk);
        if (inst_valid !== 1'b0) begin
            $display("MISMATCH inst_valid_o: got %h expected 0", inst_valid);
            test_errs++;
        end
        step();
        ctrl = '0;
        pc = snap.slot0.valid ? snap.slot0.addr : snap.slot1.addr;
        follow(model_next(pc), 1, 1'b0);
        report_test("stall and flush");
    endtask

    task automatic test_resp_error();
        bit seen;
        test_errs = 0;
        i_mem.err_addr = 32'h2c8;
        i_mem.err_en   = 1'b1;
        drive_jump(32'h2c0);
        follow(32'h2c0, 1, 1'b0);
        seen = 1'b0;
        for (int c = 0; c < 40 && !seen; c++) begin
            @(negedge clk);
            seen = rd_err;
        end
        if (!seen) begin
            $display("no read error reported within 40 cycles");
            test_errs++;
        end
        @(negedge clk);
        if (rd_err !== 1'b0) begin
            $display("MISMATCH read_resp_error_o: got %h expected 0", rd_err);
            test_errs++;
        end
        if (inst_valid !== 1'b0) begin
            $display("bundle delivered for an error beat");
            test_errs++;
        end
        follow(32'h2d0, 1, 1'b0);
        i_mem.err_en = 1'b0;
        report_test("read response error");
    endtask

    initial begin
        void'($urandom(32'heafeaeb3));
        clk       = 1'b0;
        rst_n     = 1'b0;
        jump      = '0;
        ctrl      = '0;
        n_pass    = 0;
        n_fail    = 0;
        n_err     = 0;
        test_errs = 0;
        for (int i = 0; i < 1024; i++) begin
            i_mem.mem[i] = fill_word(32'(i) << 2);
            tgt[i]       = '0;
        end
        put_branch(32'h200, 32'h210, 1'b0);     // forward, falls through
        put_branch(32'h20c, 32'h240, 1'b1);     // jal in slot1
        put_branch(32'h240, 32'h230, 1'b0);     // backward loop in slot0
        i_mem.latency  = $urandom % 6;
        i_mem.err_en   = 1'b0;
        i_mem.err_addr = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_sequential();
        test_predict();
        test_jump();
        test_misaligned();
        test_stall_flush();
        test_resp_error();
        $display("tests: %0d passed, %0d failed, %0d errors", n_pass, n_fail, n_err);
        if (n_err == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
